// File: src/tetrisPkg.sv
package tetrisPkg;

	localparam int boardWidth = 10;
	localparam int boardHeight = 20;

	// bit c of a row is column c
	typedef logic [boardWidth-1:0] rowT;
	typedef logic [4:0] rowIndexT;
	typedef logic [4:0] colIndexT;
	typedef logic [3:0] shapeT;
	typedef logic [15:0] scoreT;

	typedef enum logic [1:0] {
		cmdNone,
		cmdLeft,
		cmdRight,
		cmdRotate
	} commandT;

	typedef enum logic [2:0] {
		stSpawn,
		stIdle,
		stMoveCheck,
		stFallCheck,
		stLock,
		stClear,
		stGameOver
	} gameStateT;

	// four cells per orientation, one nibble each, cell 0 in the top nibble
	// nibble is {row offset, col offset}, two bits apiece
	// unused codes 0, 14 and 15 fall back to the square
	localparam logic [15:0] shapeOffsets [0:15] = '{
		16'h0145,
		16'h0145,
		16'h0156,
		16'h4158,
		16'h0123,
		16'h048C,
		16'h0456,
		16'h0148,
		16'h0126,
		16'h8159,
		16'h0125,
		16'h4159,
		16'h4156,
		16'h0458,
		16'h0145,
		16'h0145
	};

	// square stays, S and I pairs swap, L and T run a four-step cycle
	localparam shapeT rotateNext [0:15] = '{
		4'd1, 4'd1, 4'd3, 4'd2,
		4'd5, 4'd4, 4'd7, 4'd8,
		4'd9, 4'd6, 4'd11, 4'd12,
		4'd13, 4'd10, 4'd1, 4'd1
	};

	localparam colIndexT spawnCol = 5'd5;

endpackage

// File: src/pieceIf.sv
`timescale 1ns/100ps

interface pieceIf import tetrisPkg::*; ();

	// cells the controller wants answered this cycle
	rowIndexT [3:0] probeRow;
	colIndexT [3:0] probeCol;
	logic probeHit;

	// piece currently in play
	rowIndexT [3:0] activeRow;
	colIndexT [3:0] activeCol;
	logic lockPiece;
	logic clearDone;

	modport controller (
		output probeRow, probeCol, activeRow, activeCol, lockPiece,
		input probeHit, clearDone
	);

	modport field (
		input probeRow, probeCol, activeRow, activeCol, lockPiece,
		output probeHit, clearDone
	);

endinterface

// File: src/shapeTable.sv
`timescale 1ns/100ps

module shapeTable import tetrisPkg::*; (
	input rowIndexT anchorRow,
	input colIndexT anchorCol,
	input shapeT shape,
	output rowIndexT [3:0] cellRow,
	output colIndexT [3:0] cellCol,
	output logic inBounds
);

	logic [15:0] offsets;

	assign offsets = shapeOffsets[shape];

	always_comb begin
		logic [5:0] rowSum;
		logic [5:0] colSum;
		logic [1:0] rowOffset;
		logic [1:0] colOffset;

		inBounds = 1'b1;
		for (int i = 0; i < 4; i++) begin
			rowOffset = offsets[15 - 4*i -: 2];
			colOffset = offsets[13 - 4*i -: 2];

			// one extra bit so a wrapped anchor cannot land back on the board
			rowSum = {1'b0, anchorRow} + {4'd0, rowOffset};
			colSum = {1'b0, anchorCol} + {4'd0, colOffset};

			cellRow[i] = rowSum[4:0];
			cellCol[i] = colSum[4:0];

			if (rowSum >= 6'(boardHeight)) begin
				inBounds = 1'b0;
			end
			if (colSum >= 6'(boardWidth)) begin
				inBounds = 1'b0;
			end
		end
	end

endmodule

// File: src/playfield.sv
`timescale 1ns/100ps

module playfield import tetrisPkg::*; (
	input logic count,
	input logic reset,
	pieceIf.field piece,
	input rowIndexT readRow,
	output rowT rowBits
);

	rowT settled [0:boardHeight-1];
	logic scanning;
	rowIndexT scanRow;
	logic rowFull;

	// off-board rows read as empty
	function automatic rowT settledRow(rowIndexT row);
		rowT bits;

		bits = '0;
		if (row < rowIndexT'(boardHeight)) begin
			bits = settled[row];
		end
		return bits;
	endfunction

	function automatic logic cellSet(rowIndexT row, colIndexT col);
		rowT bits;

		bits = settledRow(row);
		return |(bits & (rowT'(1) << col));
	endfunction

	// active cells that sit in one row
	function automatic rowT pieceBits(rowIndexT row);
		rowT bits;

		bits = '0;
		for (int i = 0; i < 4; i++) begin
			if (piece.activeRow[i] == row) begin
				bits = bits | (rowT'(1) << piece.activeCol[i]);
			end
		end
		return bits;
	endfunction

	// collision answer in the same cycle
	always_comb begin
		piece.probeHit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			piece.probeHit = piece.probeHit | cellSet(piece.probeRow[i], piece.probeCol[i]);
		end
	end

	assign rowBits = settledRow(readRow) | pieceBits(readRow);
	assign rowFull = &settledRow(scanRow);

	always_ff @(posedge count) begin
		if (reset) begin
			for (int r = 0; r < boardHeight; r++) begin
				settled[r] <= '0;
			end
			scanning <= 1'b0;
			scanRow <= '0;
			piece.clearDone <= 1'b0;
		end else begin
			piece.clearDone <= 1'b0;
			if (piece.lockPiece) begin
				for (int r = 0; r < boardHeight; r++) begin
					settled[r] <= settled[r] | pieceBits(rowIndexT'(r));
				end
				// scan from the bottom once the cells are in
				scanning <= 1'b1;
				scanRow <= rowIndexT'(boardHeight - 1);
			end else if (scanning) begin
				if (rowFull) begin
					// drop everything above, then look at the same row again
					settled[0] <= '0;
					for (int r = 1; r < boardHeight; r++) begin
						if (rowIndexT'(r) <= scanRow) begin
							settled[r] <= settled[r-1];
						end
					end
				end else if (scanRow == '0) begin
					scanning <= 1'b0;
					piece.clearDone <= 1'b1;
				end else begin
					scanRow <= scanRow - 1'b1;
				end
			end
		end
	end

endmodule

// File: src/gameController.sv
`timescale 1ns/100ps

module gameController import tetrisPkg::*; (
	input logic count,
	input logic reset,
	input logic cmdValid,
	output logic cmdReady,
	input commandT cmdCode,
	input shapeT pieceKind,
	output scoreT score,
	output logic gameOver,
	pieceIf.controller piece
);

	gameStateT state;
	commandT command;

	// active piece anchor and orientation
	rowIndexT anchorRow;
	colIndexT anchorCol;
	shapeT shape;

	// candidate placement for the current state
	rowIndexT candRow;
	colIndexT candCol;
	shapeT candShape;
	logic candInBounds;
	logic candFits;
	logic takeCandidate;
	shapeT spawnShape;

	// only the five spawn orientations are accepted
	always_comb begin
		case (pieceKind)
			4'd1, 4'd2, 4'd4, 4'd6, 4'd10: spawnShape = pieceKind;
			default: spawnShape = 4'd1;
		endcase
	end

	always_comb begin
		candRow = anchorRow;
		candCol = anchorCol;
		candShape = shape;
		case (state)
			stSpawn: begin
				candRow = '0;
				candCol = spawnCol;
				candShape = spawnShape;
			end
			stMoveCheck: begin
				case (command)
					// column 0 wraps to 31 and fails the bounds test
					cmdLeft: candCol = anchorCol - 1'b1;
					cmdRight: candCol = anchorCol + 1'b1;
					cmdRotate: candShape = rotateNext[shape];
					default: candShape = shape;
				endcase
			end
			stFallCheck: begin
				candRow = anchorRow + 1'b1;
			end
			default: begin
				candShape = shape;
			end
		endcase
	end

	shapeTable cells (
		.anchorRow(candRow),
		.anchorCol(candCol),
		.shape(candShape),
		.cellRow(piece.probeRow),
		.cellCol(piece.probeCol),
		.inBounds(candInBounds)
	);

	assign candFits = candInBounds && !piece.probeHit;

	assign cmdReady = (state == stIdle);
	assign gameOver = (state == stGameOver);
	assign piece.lockPiece = (state == stLock);

	always_ff @(posedge count) begin
		if (reset) begin
			state <= stSpawn;
			command <= cmdNone;
			score <= '0;
		end else begin
			case (state)
				stSpawn: begin
					state <= candFits ? stIdle : stGameOver;
				end
				stIdle: begin
					if (cmdValid) begin
						command <= cmdCode;
						state <= stMoveCheck;
					end
				end
				stMoveCheck: begin
					state <= stFallCheck;
				end
				stFallCheck: begin
					// blocked below means the piece settles
					state <= candFits ? stIdle : stLock;
				end
				stLock: begin
					score <= score + 1'b1;
					state <= stClear;
				end
				stClear: begin
					if (piece.clearDone) begin
						state <= stSpawn;
					end
				end
				stGameOver: begin
					state <= stGameOver;
				end
				default: begin
					state <= stSpawn;
				end
			endcase
		end
	end

	// spawn always loads, so a blocked spawn still shows on the board
	assign takeCandidate = (state == stSpawn) ||
		(candFits && (state == stMoveCheck || state == stFallCheck));

	always_ff @(posedge count) begin
		if (takeCandidate) begin
			anchorRow <= candRow;
			anchorCol <= candCol;
			shape <= candShape;
			piece.activeRow <= piece.probeRow;
			piece.activeCol <= piece.probeCol;
		end
	end

endmodule

// File: src/tetrisGame.sv
`timescale 1ns/100ps

module tetrisGame import tetrisPkg::*; (
	input logic count,
	input logic reset,
	input logic cmdValid,
	output logic cmdReady,
	input commandT cmdCode,
	input shapeT pieceKind,
	input rowIndexT readRow,
	output rowT rowBits,
	output scoreT score,
	output logic gameOver
);

	pieceIf pieceBus ();

	// piece motion, score and game flow
	gameController controller (
		.count(count),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdCode(cmdCode),
		.pieceKind(pieceKind),
		.score(score),
		.gameOver(gameOver),
		.piece(pieceBus.controller)
	);

	// settled cells and row removal
	playfield field (
		.count(count),
		.reset(reset),
		.piece(pieceBus.field),
		.readRow(readRow),
		.rowBits(rowBits)
	);

endmodule

// File: verification/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic count,
	output logic reset
);

	// 40 ns period
	initial begin
		count = 1'b0;
		forever begin
			#20 count = ~count;
		end
	end

	// high over two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge count);
		@(negedge count);
		reset = 1'b0;
	end

endmodule

// File: verification/tetrisGameChecker.sv
`timescale 1ns/100ps

module tetrisGameChecker import tetrisPkg::*; (
	input logic count,
	input logic reset,
	input logic cmdValid,
	input logic cmdReady,
	input scoreT score,
	input logic gameOver
);

	// move check and fall check take the two cycles after an accept
	acceptGap: assert property (@(posedge count) disable iff (reset)
		cmdValid && cmdReady |=> !cmdReady ##1 !cmdReady)
		else $error("cmdReady high within two cycles of an accept");

	gameOverHeld: assert property (@(posedge count) disable iff (reset)
		gameOver |=> gameOver)
		else $error("gameOver fell without reset");

	scoreRising: assert property (@(posedge count) disable iff (reset)
		!reset |=> score >= $past(score))
		else $error("score decreased");

	noReadyAfterEnd: assert property (@(posedge count) disable iff (reset)
		!(cmdReady && gameOver))
		else $error("cmdReady high while gameOver");

endmodule

bind tetrisGame tetrisGameChecker protocolCheck (
	.count(count),
	.reset(reset),
	.cmdValid(cmdValid),
	.cmdReady(cmdReady),
	.score(score),
	.gameOver(gameOver)
);

// File: verification/tetrisGameTb.sv
`timescale 1ns/100ps

module tetrisGameTb import tetrisPkg::*; ();

	logic count;
	logic powerReset;
	logic gameReset;
	logic reset;
	logic cmdValid;
	logic cmdReady;
	commandT cmdCode;
	shapeT pieceKind;
	rowIndexT readRow;
	rowT rowBits;
	scoreT score;
	logic gameOver;

	// reference model of board and active piece
	rowT modelBoard [0:boardHeight-1];
	int modelRow;
	int modelCol;
	shapeT modelShape;
	scoreT modelScore;
	logic modelOver;

	int seed;
	int commandTotal;
	int cycleLimit;
	int cycles = 0;
	int gamesEnded = 0;

	assign reset = powerReset | gameReset;

	clockGen clocks (.count(count), .reset(powerReset));

	tetrisGame dut (
		.count(count),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdCode(cmdCode),
		.pieceKind(pieceKind),
		.readRow(readRow),
		.rowBits(rowBits),
		.score(score),
		.gameOver(gameOver)
	);

	// row or column offset of cell i, from the nibble table
	function automatic int cellOffset(shapeT s, int i, logic colPart);
		logic [15:0] cells;

		cells = shapeOffsets[s];
		return colPart ? int'(cells[13 - 4*i -: 2]) : int'(cells[15 - 4*i -: 2]);
	endfunction

	function automatic shapeT nextOrientation(shapeT s);
		case (s)
			4'd2: return 4'd3;
			4'd3: return 4'd2;
			4'd4: return 4'd5;
			4'd5: return 4'd4;
			4'd6: return 4'd7;
			4'd7: return 4'd8;
			4'd8: return 4'd9;
			4'd9: return 4'd6;
			4'd10: return 4'd11;
			4'd11: return 4'd12;
			4'd12: return 4'd13;
			4'd13: return 4'd10;
			default: return 4'd1;
		endcase
	endfunction

	function automatic logic pieceFits(int row, int col, shapeT s);
		int r;
		int c;
		logic fits;

		fits = 1'b1;
		for (int i = 0; i < 4; i++) begin
			r = row + cellOffset(s, i, 1'b0);
			c = col + cellOffset(s, i, 1'b1);
			if (r < 0 || r >= boardHeight || c < 0 || c >= boardWidth) begin
				fits = 1'b0;
			end else if ((modelBoard[r] & (rowT'(1) << c)) != '0) begin
				fits = 1'b0;
			end
		end
		return fits;
	endfunction

	function automatic rowT modelRowBits(int row);
		rowT bits;

		bits = modelBoard[row];
		for (int i = 0; i < 4; i++) begin
			if (modelRow + cellOffset(modelShape, i, 1'b0) == row) begin
				bits = bits | (rowT'(1) << (modelCol + cellOffset(modelShape, i, 1'b1)));
			end
		end
		return bits;
	endfunction

	function automatic void spawnModelPiece(shapeT kind);
		case (kind)
			4'd1, 4'd2, 4'd4, 4'd6, 4'd10: modelShape = kind;
			default: modelShape = 4'd1;
		endcase
		modelRow = 0;
		modelCol = 5;
		modelOver = !pieceFits(0, 5, modelShape);
	endfunction

	// full rows vanish, everything above drops
	function automatic void removeFullRows();
		rowT kept [0:boardHeight-1];
		int dst;

		dst = boardHeight - 1;
		for (int r = boardHeight - 1; r >= 0; r--) begin
			if (modelBoard[r] != '1) begin
				kept[dst] = modelBoard[r];
				dst--;
			end
		end
		for (int r = dst; r >= 0; r--) begin
			kept[r] = '0;
		end
		modelBoard = kept;
	endfunction

	function automatic void resetModel(shapeT kind);
		for (int r = 0; r < boardHeight; r++) begin
			modelBoard[r] = '0;
		end
		modelScore = '0;
		spawnModelPiece(kind);
	endfunction

	// move, then fall or lock; returns high when the piece locked
	function automatic logic applyCommand(commandT cmd, shapeT kind);
		int newCol;
		shapeT newShape;

		newCol = modelCol;
		newShape = modelShape;
		case (cmd)
			cmdLeft: newCol = modelCol - 1;
			cmdRight: newCol = modelCol + 1;
			cmdRotate: newShape = nextOrientation(modelShape);
			default: newShape = modelShape;
		endcase
		if (pieceFits(modelRow, newCol, newShape)) begin
			modelCol = newCol;
			modelShape = newShape;
		end
		if (pieceFits(modelRow + 1, modelCol, modelShape)) begin
			modelRow++;
			return 1'b0;
		end
		for (int i = 0; i < 4; i++) begin
			modelBoard[modelRow + cellOffset(modelShape, i, 1'b0)] |=
				rowT'(1) << (modelCol + cellOffset(modelShape, i, 1'b1));
		end
		modelScore = modelScore + 16'd1;
		removeFullRows();
		spawnModelPiece(kind);
		return 1'b1;
	endfunction

	task automatic compareValue(string name, logic [31:0] got, logic [31:0] expected);
		assert (got === expected) else begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// read every row, sampled mid-cycle while the DUT sits still
	task automatic compareState();
		for (int r = 0; r < boardHeight; r++) begin
			@(negedge count);
			readRow = rowIndexT'(r);
			#10;
			compareValue($sformatf("rowBits[%0d]", r), 32'(rowBits), 32'(modelRowBits(r)));
		end
		compareValue("score", 32'(score), 32'(modelScore));
		compareValue("gameOver", 32'(gameOver), 32'(modelOver));
	endtask

	task automatic waitSettled();
		@(negedge count);
		while (!cmdReady && !gameOver) begin
			@(negedge count);
		end
	endtask

	task automatic runCommand(commandT cmd, shapeT kind, output int latency);
		@(negedge count);
		cmdValid = 1'b1;
		cmdCode = cmd;
		pieceKind = kind;
		@(negedge count);
		latency = 1;
		cmdValid = 1'b0;
		cmdCode = cmdNone;
		while (!cmdReady && !gameOver) begin
			@(negedge count);
			latency++;
		end
	endtask

	task automatic holdGameOver();
		repeat (4) begin
			@(negedge count);
			assert (gameOver && !cmdReady) else begin
				$display("game over was left, or cmdReady rose after game over");
				$display("RESULT: FAIL");
				$fatal(1, "game over not held");
			end
		end
	endtask

	task automatic restartGame();
		@(negedge count);
		gameReset = 1'b1;
		repeat (2) @(negedge count);
		gameReset = 1'b0;
		resetModel(pieceKind);
		waitSettled();
		compareState();
	endtask

	always @(posedge count) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("timeout: no result within %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int pick;
		int latency;
		logic locked;
		commandT cmd;
		shapeT kind;

		seed = 32'hfa3da98d;
		commandTotal = 400;
		cycleLimit = commandTotal * 40 + 200;
		gameReset = 1'b0;
		cmdValid = 1'b0;
		cmdCode = cmdNone;
		readRow = '0;
		pick = $random(seed);
		pieceKind = shapeT'(pick[3:0]);

		wait (!powerReset);
		resetModel(pieceKind);
		waitSettled();
		compareState();

		for (int n = 0; n < commandTotal; n++) begin
			pick = $random(seed);
			kind = shapeT'(pick[3:0]);
			// odd hundreds stack pieces in the middle to reach game over
			if ((n / 100) % 2 == 1) begin
				cmd = pick[4] ? cmdRotate : cmdNone;
			end else begin
				cmd = commandT'(pick[5:4]);
			end
			runCommand(cmd, kind, latency);
			locked = applyCommand(cmd, kind);
			compareState();
			if (!locked) begin
				compareValue("cmdReady latency", 32'(latency), 32'd3);
			end
			if (modelOver) begin
				gamesEnded++;
				holdGameOver();
				restartGame();
			end
		end

		$display("%0d commands, %0d games ended", commandTotal, gamesEnded);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: tetrisGame.f
src/tetrisPkg.sv
src/pieceIf.sv
src/shapeTable.sv
src/playfield.sv
src/gameController.sv
src/tetrisGame.sv
verification/clockGen.sv
verification/tetrisGameChecker.sv
verification/tetrisGameTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tetrisGameTb
FILELIST ?= tetrisGame.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
